// ==== verilog/pr_pkg.sv ====
package pr_pkg;

	// Command opcodes, one command per four-phase cycle
	typedef enum logic [2:0] {
		OP_WREG  = 3'd0,	// W -> Rn, n=0 targets R0
		OP_RREG  = 3'd1,	// Rn -> L
		OP_RR0SH = 3'd2,	// R0>>8 -> L
		OP_WSR   = 3'd3,	// W -> Q, BS, NB
		OP_RSR   = 3'd4,	// System register -> L
		OP_FLAGS = 3'd5,	// ALU status -> R0 flags
		OP_CLM   = 3'd6	// Master clear
	} pr_op_e;

	// ALU status seen at flag update time
	typedef struct packed {
		logic zs;			// Result zero
		logic s0;			// Result sign
		logic s_1;		// Sign of arithmetic difference
		logic carry;
		logic aryt;		// Arithmetic compare, logical when low
		logic ovf;		// Overflow
		logic ust_z;	// Z update enable
		logic ust_mc;	// M and C update enable
		logic ust_v;	// V set enable
		logic ust_leg;	// L, E, G update enable
	} pr_alu_t;

	// One command word, 32 bits wide
	typedef struct packed {
		pr_op_e      op;
		logic [2:0]  addr;	// Register number, 0 is R0
		logic [15:0] w;			// W bus word
		pr_alu_t     alu;
	} pr_cmd_t;

	// R0 seen as CPU flags, MSB first
	typedef struct packed {
		logic       z;		// Zero
		logic       m;		// Minus
		logic       v;		// Overflow, sticky
		logic       c;		// Carry
		logic       l;		// Less
		logic       e;		// Equal
		logic       g;		// Greater
		logic       y;
		logic       x;
		logic [6:0] low;	// Plain register bits
	} pr_flag_t;

	// R0 as a plain word or as flags
	typedef union packed {
		logic [15:0] word;
		pr_flag_t    f;
	} pr_r0_u;

	// Read result on the L bus
	typedef struct packed {
		logic [15:0] data;
	} pr_resp_t;

	// High R0 bits a user-mode write cannot touch
	localparam int R0_PROT_BITS = 8;

endpackage

// ==== verilog/pr_cmd_in.sv ====
`timescale 1ns/1ps

module pr_cmd_in (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            cmd_req,
	input  pr_pkg::pr_cmd_t cmd,
	input  logic            busy,		// Response still pending
	output logic            cmd_ack,
	output pr_pkg::pr_cmd_t exec_cmd,
	output logic            do_wreg,
	output logic            do_wr0,
	output logic            do_wsr,
	output logic            do_flags,
	output logic            do_clm,
	output logic            do_read
);

	logic accept;	// Req taken this edge
	logic r0_sel;	// Address 0 means R0
	logic wr_op;
	logic rd_op;

	// New req only while idle and no response outstanding
	assign accept = cmd_req & ~cmd_ack & ~busy;
	assign r0_sel = (cmd.addr == 3'd0);
	assign wr_op  = (cmd.op == pr_pkg::OP_WREG);

	// Three flavours of read all go out on L
	assign rd_op = (cmd.op == pr_pkg::OP_RREG)
		| (cmd.op == pr_pkg::OP_RR0SH)
		| (cmd.op == pr_pkg::OP_RSR);

	// Ack side of the four-phase pair
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_ack <= 1'b0;
		end else if (accept) begin
			cmd_ack <= 1'b1;	// Data latched below on same edge
		end else if (cmd_ack && !cmd_req) begin
			cmd_ack <= 1'b0;	// Sender let go, cycle closed
		end
	end

	// Command register, held until next accept
	always_ff @(posedge clk) begin
		if (accept) begin
			exec_cmd <= cmd;
		end
	end

	// Strobes live for the one cycle after accept
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			do_wreg  <= 1'b0;
			do_wr0   <= 1'b0;
			do_wsr   <= 1'b0;
			do_flags <= 1'b0;
			do_clm   <= 1'b0;
			do_read  <= 1'b0;
		end else begin
			do_wreg  <= accept & wr_op & ~r0_sel;	// R1..R7
			do_wr0   <= accept & wr_op & r0_sel;	// R0 path, Q checked later
			do_wsr   <= accept & (cmd.op == pr_pkg::OP_WSR);
			do_flags <= accept & (cmd.op == pr_pkg::OP_FLAGS);
			do_clm   <= accept & (cmd.op == pr_pkg::OP_CLM);
			do_read  <= accept & rd_op;
		end
	end

endmodule

// ==== verilog/pr_user_regs.sv ====
`timescale 1ns/1ps

module pr_user_regs (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [2:0]  addr,
	input  logic [15:0] w,
	output logic [15:0] rd
);

	// R1..R7, no storage behind address 0
	logic [15:0] regs [1:7];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i <= 7; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (we && (addr != 3'd0)) begin
			regs[addr] <= w;	// Write strobe from the cmd side
		end
	end

	// Async read, R0 slot reads as zero here
	assign rd = (addr == 3'd0) ? 16'h0000 : regs[addr];

endmodule

// ==== verilog/pr_flags.sv ====
`timescale 1ns/1ps

module pr_flags (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr,		// Plain R0 write
	input  logic              upd,		// Flag update from ALU
	input  logic              clr,		// Master clear
	input  logic              q,			// User mode
	input  logic [15:0]       w,
	input  pr_pkg::pr_alu_t   alu,
	output pr_pkg::pr_r0_u    r0
);

	// Bits still writable in user mode
	localparam int LOW_BITS = 16 - pr_pkg::R0_PROT_BITS;

	pr_pkg::pr_r0_u r0_q;
	pr_pkg::pr_r0_u r0_d;
	logic           leg_l;	// Less, per compare type
	logic           leg_e;	// Equal

	// Arithmetic compare uses sign of difference, logical uses carry
	assign leg_l = alu.aryt ? alu.s_1 : alu.carry;
	assign leg_e = alu.zs;

	always_comb begin
		r0_d = r0_q;
		if (clr) begin
			r0_d.word = 16'h0000;
		end else if (wr) begin
			if (q) begin
				// User mode, flag byte kept
				r0_d.word = {r0_q.word[15:LOW_BITS], w[LOW_BITS-1:0]};
			end else begin
				r0_d.word = w;
			end
		end else if (upd) begin
			if (alu.ust_z) begin
				r0_d.f.z = alu.zs;
			end
			if (alu.ust_mc) begin
				r0_d.f.m = alu.s0;
				r0_d.f.c = alu.carry;
			end
			if (alu.ust_v && alu.ovf) begin
				r0_d.f.v = 1'b1;	// Sticky, only a write or clear drops it
			end
			if (alu.ust_leg) begin
				r0_d.f.l = leg_l;
				r0_d.f.e = leg_e;
				r0_d.f.g = ~(leg_l | leg_e);	// Neither less nor equal
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r0_q.word <= 16'h0000;
		end else begin
			r0_q <= r0_d;
		end
	end

	assign r0 = r0_q;

endmodule

// ==== verilog/pr_sysreg.sv ====
`timescale 1ns/1ps

module pr_sysreg #(
	parameter int CPU_NUMBER = 0	// Which of the two CPUs this is
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        load,		// W -> Q, BS, NB
	input  logic        clr,		// Master clear
	input  logic [15:0] w,
	output logic        q,			// User mode flag
	output logic [15:0] sr_word
);

	logic       bs;			// Memory segment select
	logic [3:0] nb;			// Block number
	logic       seg_rel;	// Segment relative to this CPU

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q  <= 1'b0;
			bs <= 1'b0;
			nb <= 4'h0;
		end else if (clr) begin
			q  <= 1'b0;	// Back to system mode
			bs <= 1'b0;
			nb <= 4'h0;
		end else if (load) begin
			q  <= w[10];
			bs <= w[11];
			nb <= w[15:12];
		end
	end

	// CPU 1 sees the segments swapped
	assign seg_rel = bs ^ (CPU_NUMBER != 0);

	// Readback in load layout, bits 0..9 unused
	assign sr_word = {nb, seg_rel, q, 10'd0};

endmodule

// ==== verilog/pr_l_out.sv ====
`timescale 1ns/1ps

module pr_l_out (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             do_read,
	input  pr_pkg::pr_op_e   op,
	input  logic [2:0]       addr,
	input  logic [15:0]      r1_7,		// User register read port
	input  pr_pkg::pr_r0_u   r0,
	input  logic [15:0]      sr_word,
	input  logic             res_ack,
	output logic             res_req,
	output pr_pkg::pr_resp_t res,
	output logic             busy		// Holds off the cmd side
);

	logic [15:0] l_word;	// Selected L bus word

	always_comb begin
		case (op)
			pr_pkg::OP_RREG:  l_word = (addr == 3'd0) ? r0.word : r1_7;
			pr_pkg::OP_RR0SH: l_word = {8'h00, r0.word[15:8]};	// Flag byte down
			pr_pkg::OP_RSR:   l_word = sr_word;
			default:          l_word = 16'h0000;
		endcase
	end

	// Req side of the response pair, busy until ack drops
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_req <= 1'b0;
			busy    <= 1'b0;
		end else if (do_read) begin
			res_req <= 1'b1;
			busy    <= 1'b1;
		end else if (res_req && res_ack) begin
			res_req <= 1'b0;	// Consumer took it
		end else if (busy && !res_req && !res_ack) begin
			busy <= 1'b0;	// Four-phase cycle done
		end
	end

	// Payload stays put while res_req is high
	always_ff @(posedge clk) begin
		if (do_read) begin
			res.data <= l_word;
		end
	end

endmodule

// ==== verilog/pr_top.sv ====
`timescale 1ns/1ps

module pr_top #(
	parameter int CPU_NUMBER = 0
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cmd_req,
	input  pr_pkg::pr_cmd_t  cmd,
	output logic             cmd_ack,
	output logic             res_req,
	output pr_pkg::pr_resp_t res,
	input  logic             res_ack,
	output logic             q
);

	pr_pkg::pr_cmd_t exec_cmd;	// Command under execution
	logic            do_wreg;
	logic            do_wr0;
	logic            do_wsr;
	logic            do_flags;
	logic            do_clm;
	logic            do_read;
	logic            busy;
	logic [15:0]     r1_7;
	pr_pkg::pr_r0_u  r0;
	logic [15:0]     sr_word;

	pr_cmd_in u_cmd_in (
		.clk(clk), .rst_n(rst_n),
		.cmd_req(cmd_req), .cmd(cmd), .busy(busy), .cmd_ack(cmd_ack),
		.exec_cmd(exec_cmd),
		.do_wreg(do_wreg), .do_wr0(do_wr0), .do_wsr(do_wsr),
		.do_flags(do_flags), .do_clm(do_clm), .do_read(do_read)
	);

	// Same address feeds write and read port
	pr_user_regs u_user_regs (
		.clk(clk), .rst_n(rst_n),
		.we(do_wreg), .addr(exec_cmd.addr), .w(exec_cmd.w), .rd(r1_7)
	);

	pr_flags u_flags (
		.clk(clk), .rst_n(rst_n),
		.wr(do_wr0), .upd(do_flags), .clr(do_clm), .q(q),
		.w(exec_cmd.w), .alu(exec_cmd.alu), .r0(r0)
	);

	pr_sysreg #(.CPU_NUMBER(CPU_NUMBER)) u_sysreg (
		.clk(clk), .rst_n(rst_n),
		.load(do_wsr), .clr(do_clm), .w(exec_cmd.w), .q(q), .sr_word(sr_word)
	);

	pr_l_out u_l_out (
		.clk(clk), .rst_n(rst_n),
		.do_read(do_read), .op(exec_cmd.op), .addr(exec_cmd.addr),
		.r1_7(r1_7), .r0(r0), .sr_word(sr_word),
		.res_ack(res_ack), .res_req(res_req), .res(res), .busy(busy)
	);

endmodule

// ==== verification/pr_props.sv ====
`timescale 1ns/1ps

module pr_props (
	input logic             clk,
	input logic             rst_n,
	input logic             cmd_req,
	input logic             cmd_ack,
	input logic             res_req,
	input logic             res_ack,
	input pr_pkg::pr_resp_t res
);

	// Ack only answers a req seen on the edge before
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> $past(cmd_req))
		else $error("cmd_ack rose without cmd_req");

	// Response frozen until the consumer acks
	res_held: assert property (@(posedge clk) disable iff (!rst_n)
		res_req && !res_ack |=> res_req && $stable(res))
		else $error("res_req or res changed before res_ack");

	no_ack_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
		res_req && !cmd_ack |=> !cmd_ack)
		else $error("cmd_ack rose while a response was pending");

endmodule

bind pr_top pr_props u_props (
	.clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
	.res_req(res_req), .res_ack(res_ack), .res(res)
);

// ==== verification/pr_checker.sv ====
`timescale 1ns/1ps

module pr_checker #(
	parameter int CPU_NUMBER = 0
) (
	input  logic             clk,
	input  logic             rst_n,
	input  pr_pkg::pr_cmd_t  cmd,
	input  logic             cmd_ack,
	input  logic [15:0]      exp_data,
	input  logic             res_req,
	input  pr_pkg::pr_resp_t res,
	input  logic             res_ack,
	input  logic             q,
	output int               error_count,
	output int               read_count
);

	logic [15:0] m_regs [1:7];	// Model of R1..R7
	logic [15:0] m_r0;					// Flags z m v c l e g from bit 15 down
	logic        m_q;
	logic        m_bs;
	logic [3:0]  m_nb;
	logic        ack_d;					// Ack as seen one edge earlier
	logic [15:0] model_fifo [$];
	logic [15:0] file_fifo [$];

	// Applies one accepted command to the model
	task automatic apply_cmd(input pr_pkg::pr_cmd_t c);
		logic less;
		case (c.op)
			pr_pkg::OP_WREG: begin
				if (c.addr != 3'd0) m_regs[c.addr] = c.w;
				else if (m_q) m_r0[7:0] = c.w[7:0];	// Flag byte locked in user mode
				else m_r0 = c.w;
			end
			pr_pkg::OP_WSR: begin
				m_q  = c.w[10];
				m_bs = c.w[11];
				m_nb = c.w[15:12];
			end
			pr_pkg::OP_FLAGS: begin
				less = c.alu.aryt ? c.alu.s_1 : c.alu.carry;
				if (c.alu.ust_z) m_r0[15] = c.alu.zs;
				if (c.alu.ust_mc) begin
					m_r0[14] = c.alu.s0;
					m_r0[12] = c.alu.carry;
				end
				if (c.alu.ust_v) m_r0[13] = m_r0[13] | c.alu.ovf;
				if (c.alu.ust_leg) begin
					m_r0[11] = less;
					m_r0[10] = c.alu.zs;
					m_r0[9]  = !less && !c.alu.zs;
				end
			end
			pr_pkg::OP_CLM: begin
				m_q  = 1'b0;
				m_bs = 1'b0;
				m_nb = 4'h0;
				m_r0 = 16'h0000;
			end
			pr_pkg::OP_RREG: model_fifo.push_back((c.addr == 3'd0) ? m_r0 : m_regs[c.addr]);
			pr_pkg::OP_RR0SH: model_fifo.push_back({8'h00, m_r0[15:8]});
			pr_pkg::OP_RSR: model_fifo.push_back({m_nb, m_bs ^ (CPU_NUMBER != 0), m_q, 10'h000});
			default: ;
		endcase
		if (c.op == pr_pkg::OP_RREG || c.op == pr_pkg::OP_RR0SH || c.op == pr_pkg::OP_RSR) begin
			file_fifo.push_back(exp_data);
		end
	endtask

	always @(posedge clk) begin
		logic [15:0] want;
		logic [15:0] file_want;
		if (!rst_n) begin
			for (int i = 1; i <= 7; i++) m_regs[i] = 16'h0000;
			m_r0        = 16'h0000;
			m_q         = 1'b0;
			m_bs        = 1'b0;
			m_nb        = 4'h0;
			ack_d       = 1'b0;
			error_count = 0;
			read_count  = 0;
		end else begin
			if (cmd_ack && !ack_d) apply_cmd(cmd);	// First edge of a new ack
			ack_d = cmd_ack;
			if (res_req && res_ack) begin
				if (model_fifo.size() == 0) begin
					$display("Response at %0t with no read command pending", $time);
					error_count++;
				end else begin
					want      = model_fifo.pop_front();
					file_want = file_fifo.pop_front();
					read_count++;
					if (res.data !== want) begin
						$display("FAIL %0t: read got %h, model expects %h", $time, res.data, want);
						error_count++;
					end
					if (res.data !== file_want) begin
						$display("FAIL %0t: read got %h, stim file expects %h",
							$time, res.data, file_want);
						error_count++;
					end
					if (q !== m_q) begin
						$display("FAIL %0t: q port is %b, model expects %b", $time, q, m_q);
						error_count++;
					end
				end
			end
		end
	end

endmodule

// ==== verification/pr_tb.sv ====
`timescale 1ns/1ps

module pr_tb;

	localparam int CLK_PERIOD  = 40;
	localparam int RST_CYCLES  = 8;
	localparam int DRIVE_DELAY = 2;	// Inputs move this long after the edge
	localparam int MAX_CMDS    = 64;
	localparam int FIELDS      = 5;	// op, addr, w, alu, expected

	logic             clk;
	logic             rst_n;
	logic             cmd_req;
	pr_pkg::pr_cmd_t  cmd;
	logic             cmd_ack;
	logic             res_req;
	pr_pkg::pr_resp_t res;
	logic             res_ack;
	logic             q;
	logic [15:0]      exp_data;	// File value that rides along with cmd
	int               error_count;
	int               read_count;
	logic [15:0]      stim [0:MAX_CMDS*FIELDS-1];
	int               n_cmds;
	int               n_reads;
	int               tb_errors;
	logic             loaded;
	integer           seed;

	pr_top #(.CPU_NUMBER(1)) UUT (
		.clk(clk), .rst_n(rst_n),
		.cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
		.res_req(res_req), .res(res), .res_ack(res_ack), .q(q)
	);

	pr_checker #(.CPU_NUMBER(1)) u_checker (
		.clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_ack(cmd_ack), .exp_data(exp_data),
		.res_req(res_req), .res(res), .res_ack(res_ack), .q(q),
		.error_count(error_count), .read_count(read_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Counts lines up to the end marker, op 7
	function automatic void count_cmds();
		logic [15:0] op;
		n_cmds  = 0;
		n_reads = 0;
		for (int i = 0; i < MAX_CMDS; i++) begin
			op = stim[i*FIELDS];
			if (op === 16'h0007) break;
			n_cmds++;
			if (op === 16'h0001 || op === 16'h0002 || op === 16'h0004) n_reads++;
		end
	endfunction

	// Full four-phase cycle for one file line
	task automatic send_cmd(input int idx);
		pr_pkg::pr_cmd_t c;
		c.op   = pr_pkg::pr_op_e'(stim[idx*FIELDS][2:0]);
		c.addr = stim[idx*FIELDS+1][2:0];
		c.w    = stim[idx*FIELDS+2];
		c.alu  = stim[idx*FIELDS+3][9:0];
		@(posedge clk);
		#DRIVE_DELAY;
		cmd      = c;
		exp_data = stim[idx*FIELDS+4];
		cmd_req  = 1'b1;
		do @(posedge clk); while (!cmd_ack);
		#DRIVE_DELAY cmd_req = 1'b0;
		do @(posedge clk); while (cmd_ack);	// Both low, cmd free to change
	endtask

	initial begin
		rst_n     = 1'b0;
		cmd_req   = 1'b0;
		cmd       = '0;
		exp_data  = 16'h0000;
		tb_errors = 0;
		loaded    = 1'b0;
		$readmemh("verification/pr_stim.txt", stim);
		count_cmds();
		loaded = 1'b1;
		if (n_cmds == 0) begin
			$display("Stimulus file held no commands");
			tb_errors++;
		end
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DELAY rst_n = 1'b1;
		for (int i = 0; i < n_cmds; i++) begin
			send_cmd(i);
		end
		wait (read_count == n_reads);	// Last response drained
		repeat (4) @(posedge clk);
		$display("Summary: %0d commands, %0d reads checked, %0d errors",
			n_cmds, read_count, error_count + tb_errors);
		if (error_count + tb_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Response consumer with a random 0..5 cycle think time
	initial begin
		int wait_cycles;
		res_ack = 1'b0;
		seed    = 32'h0d5a7189;
		forever begin
			do @(posedge clk); while (!res_req);
			wait_cycles = $unsigned($random(seed)) % 6;
			repeat (wait_cycles) @(posedge clk);
			#DRIVE_DELAY res_ack = 1'b1;
			do @(posedge clk); while (res_req);
			#DRIVE_DELAY res_ack = 1'b0;
		end
	end

	// Budget of 20 cycles per line on top of reset
	initial begin
		wait (loaded);
		#((n_cmds * 20 + RST_CYCLES) * CLK_PERIOD);
		$display("Timeout after %0d cycles, handshake stuck", n_cmds * 20 + RST_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verification/pr_stim.txt ====
// Columns: op addr w alu expected, all hex, expected only used on reads
// op 0 WREG 1 RREG 2 RR0SH 3 WSR 4 RSR 5 FLAGS 6 CLM 7 end of list
0 1 1234 000 0000
0 7 beef 000 0000
0 0 a5c3 000 0000
1 1 0000 000 1234
1 7 0000 000 beef
1 0 0000 000 a5c3
2 0 0000 000 00a5
0 0 0000 000 0000
5 0 0000 1bf 0000
1 0 0000 000 6800
5 0 0000 047 0000
1 0 0000 000 3800
5 0 0000 229 0000
5 0 0000 001 0000
2 0 0000 000 00b2
3 0 5c00 000 0000
4 0 0000 000 5400
0 0 1177 000 0000
1 0 0000 000 b277
0 3 0f0f 000 0000
6 0 0000 000 0000
4 0 0000 000 0800
1 0 0000 000 0000
1 1 0000 000 1234
1 3 0000 000 0f0f
3 0 a000 000 0000
4 0 0000 000 a800
0 0 ffff 000 0000
5 0 0000 008 0000
1 0 0000 000 7fff
7 0 0000 000 0000

// ==== filelist.f ====
verilog/pr_pkg.sv
verilog/pr_cmd_in.sv
verilog/pr_user_regs.sv
verilog/pr_flags.sv
verilog/pr_sysreg.sv
verilog/pr_l_out.sv
verilog/pr_top.sv
verification/pr_props.sv
verification/pr_checker.sv
verification/pr_tb.sv

// ==== Makefile ====
# Verilator build and run of the register unit testbench
VERILATOR ?= verilator
TOP       ?= pr_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
